//--- include/alveo_shell_defines.svh
`ifndef ALVEO_SHELL_DEFINES_SVH
`define ALVEO_SHELL_DEFINES_SVH

// Host APB bus
`define ALVEO_APB_ADDR_WID 16
`define ALVEO_APB_DATA_WID 32

// Device identifier, read back as three APB words
`define ALVEO_DNA_WID 96

// Application stream path
`define ALVEO_STREAM_WID 32
// Power of two, 4 or more
`define ALVEO_FIFO_DEPTH 16

// Constant register contents
`define ALVEO_BUILD_TIMESTAMP 32'h5F3A_1C20
`define ALVEO_UNMAPPED_RDATA 32'hDEAD_C0DE

`endif

//--- hdl/alveo_shell_pkg.sv
`default_nettype none

package alveo_shell_pkg;

    // Platform address map, taken from paddr[13:12]
    // Each region is a 4 KB window
    typedef enum logic [1:0] {
        REGION_SYSCFG = 2'd0,
        REGION_FIFO   = 2'd1,
        REGION_NONE_2 = 2'd2,
        REGION_NONE_3 = 2'd3
    } apb_region_e;

    // DNA reader sequence
    // One read pulse, then one shift per identifier bit
    typedef enum logic [1:0] {
        IDLE,
        READ,
        SHIFT,
        DONE
    } dna_state_e;

endpackage : alveo_shell_pkg

`default_nettype wire

//--- hdl/syscfg_reg_pkg.sv
`default_nettype none

package syscfg_reg_pkg;

    // System config window, byte offsets within the region
    typedef enum logic [11:0] {
        // Bit 0 is dna_valid
        STATUS  = 12'h000,
        BUILD   = 12'h004,
        SCRATCH = 12'h008,
        // Identifier, most significant word first
        DNA_HI  = 12'h00C,
        DNA_MID = 12'h010,
        DNA_LO  = 12'h014
    } syscfg_reg_e;

    // Stream FIFO window, read only
    typedef enum logic [11:0] {
        PKT_COUNT = 12'h000,
        LEVEL     = 12'h004
    } fifo_reg_e;

endpackage : syscfg_reg_pkg

`default_nettype wire

//--- hdl/alveo_shell_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "alveo_shell_defines.svh"

module alveo_shell_decoder
    import alveo_shell_pkg::*;
(
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // Host APB
    input  wire logic                           i_psel,
    input  wire logic                           i_penable,
    input  wire logic                           i_pwrite,
    input  wire logic [`ALVEO_APB_ADDR_WID-1:0] i_paddr,
    output logic      [`ALVEO_APB_DATA_WID-1:0] o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    // System config target
    output logic                                o_syscfg_psel,
    input  wire logic [`ALVEO_APB_DATA_WID-1:0] i_syscfg_prdata,
    input  wire logic                           i_syscfg_pready,
    input  wire logic                           i_syscfg_pslverr,
    // Stream FIFO target
    output logic                                o_fifo_psel,
    input  wire logic [`ALVEO_APB_DATA_WID-1:0] i_fifo_prdata,
    input  wire logic                           i_fifo_pready,
    input  wire logic                           i_fifo_pslverr
);

    apb_region_e region;
    logic        access;

    assign region = apb_region_e'(i_paddr[13:12]);
    // Zero-wait access phase
    assign access = i_psel && i_penable;

    // ==========================================================
    // Target selects
    // ==========================================================
    assign o_syscfg_psel = i_psel && (region == REGION_SYSCFG);
    assign o_fifo_psel   = i_psel && (region == REGION_FIFO);

    // ==========================================================
    // Response mux
    // ==========================================================
    always_comb begin
        case (region)
            REGION_SYSCFG: begin
                o_prdata  = i_syscfg_prdata;
                o_pready  = i_syscfg_pready;
                o_pslverr = i_syscfg_pslverr;
            end
            REGION_FIFO: begin
                o_prdata  = i_fifo_prdata;
                o_pready  = i_fifo_pready;
                o_pslverr = i_fifo_pslverr;
            end
            // Terminator, completes with an error
            REGION_NONE_2, REGION_NONE_3: begin
                o_prdata  = `ALVEO_UNMAPPED_RDATA;
                o_pready  = access;
                o_pslverr = access;
            end
        endcase
    end

    // ==========================================================
    // Assertions
    // ==========================================================
    // No two targets selected at once
    a_sel_onehot0 : assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0({o_syscfg_psel, o_fifo_psel}));

    // Host holds the address from setup into access
    a_paddr_stable : assert property (@(posedge i_clk) disable iff (i_rst)
        (i_psel && !i_penable) |=> (i_penable && $stable(i_paddr)));

endmodule : alveo_shell_decoder

`default_nettype wire

//--- hdl/syscfg_reg_blk.sv
`timescale 1ns/100ps
`default_nettype none

`include "alveo_shell_defines.svh"

module syscfg_reg_blk
    import syscfg_reg_pkg::*;
(
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // APB target
    input  wire logic                           i_psel,
    input  wire logic                           i_penable,
    input  wire logic                           i_pwrite,
    input  wire logic [`ALVEO_APB_ADDR_WID-1:0] i_paddr,
    input  wire logic [`ALVEO_APB_DATA_WID-1:0] i_pwdata,
    output logic      [`ALVEO_APB_DATA_WID-1:0] o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    // Device identifier from the DNA reader
    input  wire logic                           i_dna_valid,
    input  wire logic [`ALVEO_DNA_WID-1:0]      i_dna
);

    syscfg_reg_e                    reg_sel;
    logic                           access;
    logic                           reg_ro;
    logic                           reg_bad;
    logic [`ALVEO_APB_DATA_WID-1:0] rd_data;
    logic [`ALVEO_APB_DATA_WID-1:0] scratch;

    // Offset within the 4 KB window
    assign reg_sel = syscfg_reg_e'(i_paddr[11:0]);
    assign access  = i_psel && i_penable;

    // ==========================================================
    // Read decode
    // ==========================================================
    always_comb begin
        reg_ro  = 1'b1;
        reg_bad = 1'b0;
        rd_data = '0;
        case (reg_sel)
            STATUS:  rd_data = {{(`ALVEO_APB_DATA_WID-1){1'b0}}, i_dna_valid};
            BUILD:   rd_data = `ALVEO_BUILD_TIMESTAMP;
            SCRATCH: begin
                rd_data = scratch;
                reg_ro  = 1'b0;
            end
            // Identifier words stay 0 until the reader is done
            DNA_HI:  rd_data = i_dna_valid ? i_dna[95:64] : '0;
            DNA_MID: rd_data = i_dna_valid ? i_dna[63:32] : '0;
            DNA_LO:  rd_data = i_dna_valid ? i_dna[31:0] : '0;
            default: reg_bad = 1'b1;
        endcase
    end

    // ==========================================================
    // APB response
    // ==========================================================
    assign o_prdata  = rd_data;
    assign o_pready  = access;
    // Unknown offset, or write to a read-only word
    assign o_pslverr = access && (reg_bad || (i_pwrite && reg_ro));

    // ==========================================================
    // Scratch register
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            scratch <= '0;
        end else if (access && i_pwrite && (reg_sel == SCRATCH)) begin
            scratch <= i_pwdata;
        end
    end

    // ==========================================================
    // Assertions
    // ==========================================================
    // Every completion follows its own setup cycle
    a_pready_access : assert property (@(posedge i_clk) disable iff (i_rst)
        o_pready |-> (i_psel && i_penable && $past(i_psel && !i_penable)));

endmodule : syscfg_reg_blk

`default_nettype wire

//--- hdl/alveo_shell_dna.sv
`timescale 1ns/100ps
`default_nettype none

`include "alveo_shell_defines.svh"

module alveo_shell_dna
    import alveo_shell_pkg::*;
(
    input  wire logic                      i_clk,
    input  wire logic                      i_rst,
    // Device identifier port
    output logic                           o_dna_read,
    output logic                           o_dna_shift,
    input  wire logic                      i_dna_dout,
    // Collected identifier
    output logic                           o_dna_valid,
    output logic      [`ALVEO_DNA_WID-1:0] o_dna
);

    localparam int CNT_WID = $clog2(`ALVEO_DNA_WID);

    dna_state_e               state;
    logic [CNT_WID-1:0]       bit_cnt;
    logic [`ALVEO_DNA_WID-1:0] dna_sr;

    // ==========================================================
    // Sequencer
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                // Leave on the first edge out of reset
                IDLE:  state <= READ;
                READ:  state <= SHIFT;
                SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_WID'(`ALVEO_DNA_WID - 1)) begin
                        state <= DONE;
                    end
                end
                // Held until the next reset
                DONE:  state <= DONE;
            endcase
        end
    end

    // Device presents MSB first, one bit per shift
    always_ff @(posedge i_clk) begin
        if (state == SHIFT) begin
            dna_sr <= {dna_sr[`ALVEO_DNA_WID-2:0], i_dna_dout};
        end
    end

    // Port controls
    assign o_dna_read  = (state == READ);
    assign o_dna_shift = (state == SHIFT);
    assign o_dna_valid = (state == DONE);
    assign o_dna       = dna_sr;

    // ==========================================================
    // Assertions
    // ==========================================================
    a_read_shift_excl : assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_dna_read && o_dna_shift));

endmodule : alveo_shell_dna

`default_nettype wire

//--- hdl/alveo_shell_stream_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "alveo_shell_defines.svh"

module alveo_shell_stream_fifo
    import syscfg_reg_pkg::*;
(
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // Stream in
    input  wire logic                           i_s_tvalid,
    input  wire logic [`ALVEO_STREAM_WID-1:0]   i_s_tdata,
    input  wire logic                           i_s_tlast,
    output logic                                o_s_tready,
    // Stream out
    output logic                                o_m_tvalid,
    output logic      [`ALVEO_STREAM_WID-1:0]   o_m_tdata,
    output logic                                o_m_tlast,
    input  wire logic                           i_m_tready,
    // APB target, read only
    input  wire logic                           i_psel,
    input  wire logic                           i_penable,
    input  wire logic                           i_pwrite,
    input  wire logic [`ALVEO_APB_ADDR_WID-1:0] i_paddr,
    output logic      [`ALVEO_APB_DATA_WID-1:0] o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr
);

    localparam int DEPTH   = `ALVEO_FIFO_DEPTH;
    localparam int AW      = $clog2(DEPTH);
    localparam int LVL_WID = AW + 1;

    // Entry is {tlast, tdata}
    logic [`ALVEO_STREAM_WID:0]     mem [DEPTH];
    logic [AW-1:0]                  wr_ptr;
    logic [AW-1:0]                  rd_ptr;
    logic [LVL_WID-1:0]             level;
    logic [LVL_WID-1:0]             mem_cnt;
    logic                           push;
    logic                           pop_mem;
    logic                           out_xfer;
    logic [`ALVEO_APB_DATA_WID-1:0] pkt_cnt;
    logic                           access;
    fifo_reg_e                      reg_sel;

    // ==========================================================
    // Buffer control
    // ==========================================================
    // Level includes the output register
    assign mem_cnt    = level - LVL_WID'(o_m_tvalid);
    assign o_s_tready = (level < LVL_WID'(DEPTH));
    assign push       = i_s_tvalid && o_s_tready;
    assign out_xfer   = o_m_tvalid && i_m_tready;
    // Refill output register when empty or draining
    assign pop_mem    = (mem_cnt != '0) && (!o_m_tvalid || i_m_tready);

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= {i_s_tlast, i_s_tdata};
        end
        if (pop_mem) begin
            {o_m_tlast, o_m_tdata} <= mem[rd_ptr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            level      <= '0;
            o_m_tvalid <= 1'b0;
            pkt_cnt    <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop_mem) rd_ptr <= rd_ptr + 1'b1;
            level <= level + LVL_WID'(push) - LVL_WID'(out_xfer);
            if (pop_mem) begin
                o_m_tvalid <= 1'b1;
            end else if (out_xfer) begin
                o_m_tvalid <= 1'b0;
            end
            // Completed packets, counted at the output
            if (out_xfer && o_m_tlast) pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    // ==========================================================
    // Register window
    // ==========================================================
    assign reg_sel  = fifo_reg_e'(i_paddr[11:0]);
    assign access   = i_psel && i_penable;
    assign o_pready = access;

    always_comb begin
        case (reg_sel)
            PKT_COUNT: o_prdata = pkt_cnt;
            LEVEL:     o_prdata = `ALVEO_APB_DATA_WID'(level);
            default:   o_prdata = '0;
        endcase
    end

    // Window has no writable words
    assign o_pslverr = access && (i_pwrite || ((reg_sel != PKT_COUNT) && (reg_sel != LEVEL)));

    // ==========================================================
    // Assertions
    // ==========================================================
    a_level_max : assert property (@(posedge i_clk) disable iff (i_rst)
        level <= LVL_WID'(DEPTH));

    // Stalled beat held unchanged
    a_out_stable : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_m_tvalid && !i_m_tready) |=>
            (o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast)));

endmodule : alveo_shell_stream_fifo

`default_nettype wire

//--- hdl/alveo_shell.sv
`timescale 1ns/100ps
`default_nettype none

`include "alveo_shell_defines.svh"

module alveo_shell (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    // Host APB
    input  wire logic                           i_psel,
    input  wire logic                           i_penable,
    input  wire logic                           i_pwrite,
    input  wire logic [`ALVEO_APB_ADDR_WID-1:0] i_paddr,
    input  wire logic [`ALVEO_APB_DATA_WID-1:0] i_pwdata,
    output logic      [`ALVEO_APB_DATA_WID-1:0] o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    // Device identifier port
    output logic                                o_dna_read,
    output logic                                o_dna_shift,
    input  wire logic                           i_dna_dout,
    // Application stream
    input  wire logic                           i_s_tvalid,
    input  wire logic [`ALVEO_STREAM_WID-1:0]   i_s_tdata,
    input  wire logic                           i_s_tlast,
    output logic                                o_s_tready,
    output logic                                o_m_tvalid,
    output logic      [`ALVEO_STREAM_WID-1:0]   o_m_tdata,
    output logic                                o_m_tlast,
    input  wire logic                           i_m_tready
);

    // Per-target APB returns
    logic                           syscfg_psel;
    logic [`ALVEO_APB_DATA_WID-1:0] syscfg_prdata;
    logic                           syscfg_pready;
    logic                           syscfg_pslverr;
    logic                           fifo_psel;
    logic [`ALVEO_APB_DATA_WID-1:0] fifo_prdata;
    logic                           fifo_pready;
    logic                           fifo_pslverr;
    // Identifier from reader to register block
    logic                           dna_valid;
    logic [`ALVEO_DNA_WID-1:0]      dna;

    // ==========================================================
    // Platform decoder
    // ==========================================================
    alveo_shell_decoder i_alveo_shell_decoder (
        .i_clk            ( i_clk ),
        .i_rst            ( i_rst ),
        .i_psel           ( i_psel ),
        .i_penable        ( i_penable ),
        .i_pwrite         ( i_pwrite ),
        .i_paddr          ( i_paddr ),
        .o_prdata         ( o_prdata ),
        .o_pready         ( o_pready ),
        .o_pslverr        ( o_pslverr ),
        .o_syscfg_psel    ( syscfg_psel ),
        .i_syscfg_prdata  ( syscfg_prdata ),
        .i_syscfg_pready  ( syscfg_pready ),
        .i_syscfg_pslverr ( syscfg_pslverr ),
        .o_fifo_psel      ( fifo_psel ),
        .i_fifo_prdata    ( fifo_prdata ),
        .i_fifo_pready    ( fifo_pready ),
        .i_fifo_pslverr   ( fifo_pslverr )
    );

    // ==========================================================
    // System config registers and DNA reader
    // ==========================================================
    syscfg_reg_blk i_syscfg_reg_blk (
        .i_clk       ( i_clk ),
        .i_rst       ( i_rst ),
        .i_psel      ( syscfg_psel ),
        .i_penable   ( i_penable ),
        .i_pwrite    ( i_pwrite ),
        .i_paddr     ( i_paddr ),
        .i_pwdata    ( i_pwdata ),
        .o_prdata    ( syscfg_prdata ),
        .o_pready    ( syscfg_pready ),
        .o_pslverr   ( syscfg_pslverr ),
        .i_dna_valid ( dna_valid ),
        .i_dna       ( dna )
    );

    alveo_shell_dna i_alveo_shell_dna (
        .i_clk       ( i_clk ),
        .i_rst       ( i_rst ),
        .o_dna_read  ( o_dna_read ),
        .o_dna_shift ( o_dna_shift ),
        .i_dna_dout  ( i_dna_dout ),
        .o_dna_valid ( dna_valid ),
        .o_dna       ( dna )
    );

    // ==========================================================
    // Stream path
    // ==========================================================
    alveo_shell_stream_fifo i_alveo_shell_stream_fifo (
        .i_clk      ( i_clk ),
        .i_rst      ( i_rst ),
        .i_s_tvalid ( i_s_tvalid ),
        .i_s_tdata  ( i_s_tdata ),
        .i_s_tlast  ( i_s_tlast ),
        .o_s_tready ( o_s_tready ),
        .o_m_tvalid ( o_m_tvalid ),
        .o_m_tdata  ( o_m_tdata ),
        .o_m_tlast  ( o_m_tlast ),
        .i_m_tready ( i_m_tready ),
        .i_psel     ( fifo_psel ),
        .i_penable  ( i_penable ),
        .i_pwrite   ( i_pwrite ),
        .i_paddr    ( i_paddr ),
        .o_prdata   ( fifo_prdata ),
        .o_pready   ( fifo_pready ),
        .o_pslverr  ( fifo_pslverr )
    );

endmodule : alveo_shell

`default_nettype wire

//--- dv/alveo_shell_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "alveo_shell_defines.svh"

module alveo_shell_tb;

    localparam int DEPTH = `ALVEO_FIFO_DEPTH;
    // Identifier loaded by the device model, MSB shifted out first
    localparam logic [`ALVEO_DNA_WID-1:0] DEVICE_ID = 96'h1A2B_3C4D_5E6F_7081_92A3_B4C5;

    logic                           i_clk;
    logic                           i_rst;
    logic                           i_psel;
    logic                           i_penable;
    logic                           i_pwrite;
    logic [`ALVEO_APB_ADDR_WID-1:0] i_paddr;
    logic [`ALVEO_APB_DATA_WID-1:0] i_pwdata;
    logic [`ALVEO_APB_DATA_WID-1:0] o_prdata;
    logic                           o_pready;
    logic                           o_pslverr;
    logic                           o_dna_read;
    logic                           o_dna_shift;
    wire logic                      i_dna_dout;
    logic                           i_s_tvalid;
    logic [`ALVEO_STREAM_WID-1:0]   i_s_tdata;
    logic                           i_s_tlast;
    logic                           o_s_tready;
    logic                           o_m_tvalid;
    logic [`ALVEO_STREAM_WID-1:0]   o_m_tdata;
    logic                           o_m_tlast;
    logic                           i_m_tready;

    // Operations from the data file
    logic [7:0]                op_q[$];
    logic [31:0]               a_q[$];
    logic [31:0]               b_q[$];
    logic [31:0]               c_q[$];
    // Expected output beats, {tlast, tdata}
    logic [32:0]               exp_q[$];
    logic [`ALVEO_DNA_WID-1:0] dna_model = '0;
    // Cycles the device model saw each port control high
    int                        read_cycles = 0;
    int                        shift_cycles = 0;
    logic [31:0]               lcg_state;
    int                        cycles = 0;
    int                        cycle_limit = 200;
    int                        stall_cnt;
    // Beats held in the FIFO, as the stream rules predict
    int                        held;
    int                        beat_idx;
    int                        value_errs;
    int                        other_errs;
    logic                      push_now;
    logic                      pop_now;

    alveo_shell i_alveo_shell (
        .i_clk       ( i_clk ),
        .i_rst       ( i_rst ),
        .i_psel      ( i_psel ),
        .i_penable   ( i_penable ),
        .i_pwrite    ( i_pwrite ),
        .i_paddr     ( i_paddr ),
        .i_pwdata    ( i_pwdata ),
        .o_prdata    ( o_prdata ),
        .o_pready    ( o_pready ),
        .o_pslverr   ( o_pslverr ),
        .o_dna_read  ( o_dna_read ),
        .o_dna_shift ( o_dna_shift ),
        .i_dna_dout  ( i_dna_dout ),
        .i_s_tvalid  ( i_s_tvalid ),
        .i_s_tdata   ( i_s_tdata ),
        .i_s_tlast   ( i_s_tlast ),
        .o_s_tready  ( o_s_tready ),
        .o_m_tvalid  ( o_m_tvalid ),
        .o_m_tdata   ( o_m_tdata ),
        .o_m_tlast   ( o_m_tlast ),
        .i_m_tready  ( i_m_tready )
    );

    // ==========================================================
    // Clock, device model, watchdog
    // ==========================================================
    always #2 i_clk = ~i_clk;

    // Load on read, then one bit per shift
    always @(posedge i_clk) begin
        if (o_dna_read) begin
            dna_model <= DEVICE_ID;
            read_cycles++;
        end else if (o_dna_shift) begin
            dna_model <= {dna_model[`ALVEO_DNA_WID-2:0], 1'b0};
            shift_cycles++;
        end
    end
    assign i_dna_dout = dna_model[`ALVEO_DNA_WID-1];

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the operations did not complete", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [32:0] expected,
                               input logic [32:0] actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errs++;
        end
    endtask

    // One clock; output side driven and checked here
    task automatic tick();
        @(negedge i_clk);
        // Transfers of the edge just passed
        held       = held + int'(push_now) - int'(pop_now);
        push_now   = 1'b0;
        i_s_tvalid = 1'b0;
        i_s_tlast  = 1'b0;
        i_m_tready = (stall_cnt == 0);
        if (stall_cnt != 0) begin
            stall_cnt--;
        end
        pop_now = o_m_tvalid && i_m_tready;
        if (pop_now) begin
            assert (exp_q.size() != 0) else begin
                $display("Output beat %0d appeared with no beat left to expect", beat_idx);
                other_errs++;
            end
            if (exp_q.size() != 0) begin
                check_value($sformatf("stream beat %0d", beat_idx), exp_q.pop_front(),
                            {o_m_tlast, o_m_tdata});
            end
            beat_idx++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_data,
                              input logic exp_err);
        string name;
        name = $sformatf("%s %04h", write ? "write" : "read", addr);
        // Setup phase
        tick();
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        // Access phase until the target completes
        tick();
        i_penable = 1'b1;
        #1;
        // Every target is zero-wait
        check_value({name, " pready"}, 33'd1, {32'b0, o_pready});
        while (!o_pready) begin
            tick();
            #1;
        end
        if (!write) begin
            check_value({name, " prdata"}, {1'b0, exp_data}, {1'b0, o_prdata});
        end
        check_value({name, " pslverr"}, {32'b0, exp_err}, {32'b0, o_pslverr});
        tick();
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic push_packet(input int beats);
        logic [31:0] data;
        for (int i = 0; i < beats; i++) begin
            data = next_random();
            // Beat offered until taken
            do begin
                tick();
                i_s_tvalid = 1'b1;
                i_s_tdata  = data;
                i_s_tlast  = (i == beats - 1);
                check_value($sformatf("s_tready with %0d held", held),
                            {32'b0, (held < DEPTH)}, {32'b0, o_s_tready});
                push_now = o_s_tready;
            end while (!push_now);
            exp_q.push_back({i_s_tlast, data});
        end
    endtask

    // Runs out any stall and every expected beat
    task automatic drain_stream();
        while (exp_q.size() != 0 || stall_cnt != 0) begin
            tick();
        end
    endtask

    task automatic read_program();
        int          fd;
        int          n;
        int          total;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        total = 3;
        fd = $fopen("dv/alveo_shell_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/alveo_shell_input.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    op = line.getc(0);
                    a  = '0;
                    b  = '0;
                    c  = '0;
                    n  = 0;
                    case (op)
                        "W", "R": begin
                            n = $sscanf(line.substr(2, line.len() - 1), "%h %h %d", a, b, c);
                            total += 3;
                        end
                        "P", "S": begin
                            n = $sscanf(line.substr(2, line.len() - 1), "%d", a);
                            total += int'(a);
                        end
                        "D": total += DEPTH + 8;
                        "#", " ", "\n", "\r": n = -1;
                        default: begin
                            $display("Stimulus line not understood: %s", line);
                            other_errs++;
                            n = -1;
                        end
                    endcase
                    if (n >= 0) begin
                        op_q.push_back(op);
                        a_q.push_back(a);
                        b_q.push_back(b);
                        c_q.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 4 * total + 200;
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_psel     = 1'b0;
        i_penable  = 1'b0;
        i_pwrite   = 1'b0;
        i_paddr    = '0;
        i_pwdata   = '0;
        i_s_tvalid = 1'b0;
        i_s_tdata  = '0;
        i_s_tlast  = 1'b0;
        i_m_tready = 1'b1;
        lcg_state  = 32'd56369;
        stall_cnt  = 0;
        held       = 0;
        beat_idx   = 0;
        value_errs = 0;
        other_errs = 0;
        push_now   = 1'b0;
        pop_now    = 1'b0;
        read_program();
        repeat (3) tick();
        i_rst = 1'b0;
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": apb_access(1'b1, a_q[i][15:0], b_q[i], 32'h0, c_q[i][0]);
                "R": apb_access(1'b0, a_q[i][15:0], 32'h0, b_q[i], c_q[i][0]);
                "P": push_packet(int'(a_q[i]));
                // Stall runs on while later operations proceed
                "S": stall_cnt = int'(a_q[i]);
                "D": drain_stream();
                default: other_errs++;
            endcase
        end
        // One read pulse, then one shift per identifier bit
        check_value("dna read cycles", 33'd1, 33'(read_cycles));
        check_value("dna shift cycles", 33'(`ALVEO_DNA_WID), 33'(shift_cycles));
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : alveo_shell_tb

`default_nettype wire

//--- dv/alveo_shell_input.txt
# Columns: op addr data err; W write, R read with expected data, err is pslverr 0 or 1
# P beats pushes a packet, S cycles stalls the output, D drains; hex addr and data
# Identifier not collected yet
R 0000 00000000 0
R 000C 00000000 0
R 0010 00000000 0
R 0014 00000000 0
# Let the DNA reader finish
S 100
D
R 0000 00000001 0
R 000C 1A2B3C4D 0
R 0010 5E6F7081 0
R 0014 92A3B4C5 0
# Build timestamp and scratch
R 0004 5F3A1C20 0
W 0008 A5A55A5A 0
R 0008 A5A55A5A 0
W 0008 0BADF00D 0
R 0008 0BADF00D 0
W 0004 FFFFFFFF 1
R 0004 5F3A1C20 0
# Unmapped regions and unknown offset
R 2000 DEADC0DE 1
W 3010 12345678 1
R 3000 DEADC0DE 1
R 0018 00000000 1
# Stream with the output free
P 5
P 3
D
# Fill the FIFO while the output is stalled
S 40
P 6
R 1004 00000006 0
P 10
R 1004 00000010 0
P 4
D
R 1000 00000005 0
R 1004 00000000 0
W 1000 00000001 1
R 1008 00000000 1

//--- verilog.f
+incdir+include
hdl/alveo_shell_pkg.sv
hdl/syscfg_reg_pkg.sv
hdl/alveo_shell_decoder.sv
hdl/syscfg_reg_blk.sv
hdl/alveo_shell_dna.sv
hdl/alveo_shell_stream_fifo.sv
hdl/alveo_shell.sv
dv/alveo_shell_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module alveo_shell_tb \
    -o alveo_shell_sim

./obj_dir/alveo_shell_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
